/* Makefile */
TOP = tb_gme

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

/* cfg_pkt_engine.sv */
`timescale 1ns/1ns

module cfg_pkt_engine import gme_pkg::*; #(
   parameter module_id_t LMID = 8'd3
) (
   input  logic        clk,
   input  logic        rst_n,
   input  cfg_word_t   cin_data,
   input  logic        cin_data_wr,
   input  logic        cin_ready,
   input  counter_t    cnt_rdata,
   output cfg_word_t   cout_data,
   output logic        cout_data_wr,
   output logic        cout_ready,
   output cnt_access_t cnt_req,
   output logic        cnt_req_vld
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WRITE,
      ST_WAIT,
      ST_READ,
      ST_FWD,
      ST_DISCARD
   } cfg_state_t;

   cfg_state_t state;
   cfg_word_t  head;
   cfg_word_t  reply;
   cfg_op_t    op;
   logic       q_empty;
   logic       q_full;
   logic       q_rd;
   logic       start;
   logic       is_start;
   logic       is_end;
   logic       for_us;
   logic       rd_req;

   sync_fifo #(.WIDTH($bits(cfg_word_t)), .DEPTH(CFG_FIFO_DEPTH)) u_cfg_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (cin_data_wr),
      .din   (cin_data),
      .rd    (q_rd),
      .dout  (head),
      .empty (q_empty),
      .full  (q_full),
      .level ()
   );

   assign cout_ready = !q_full;

   // ************************************************************************
   // head word decode
   // ************************************************************************
   assign op       = cfg_op_t'(head[CFG_OP_LSB +: $bits(cfg_op_t)]);
   assign is_start = (head[CFG_CTL_LSB +: 2] == CFG_CTL_START);
   assign is_end   = (head[CFG_CTL_LSB +: 2] == CFG_CTL_END);
   assign for_us   = (head[CFG_DST_LSB +: $bits(module_id_t)] == LMID);

   // downstream readiness only checked before a packet starts
   assign start  = (state == ST_IDLE) && !q_empty && cin_ready;
   assign rd_req = start && for_us && is_start && (op == CFG_OP_READ);

   assign q_rd = !q_empty && ((state == ST_WRITE) || (state == ST_READ) ||
                              (state == ST_FWD) || (state == ST_DISCARD));

   always_comb begin
      cnt_req.wr   = (state == ST_WRITE);
      cnt_req.addr = head[CFG_ADDR_LSB +: $bits(cnt_addr_t)];
      cnt_req.data = head[CFG_DATA_LSB +: $bits(counter_t)];
      cnt_req_vld  = (state == ST_WRITE) || rd_req;
   end

   // read ack, ids swapped and counter in the data field
   always_comb begin
      reply = head;
      reply[CFG_OP_LSB +: $bits(cfg_op_t)] = CFG_OP_READ_ACK;
      reply[CFG_SRC_LSB +: $bits(module_id_t)] = head[CFG_DST_LSB +: $bits(module_id_t)];
      reply[CFG_DST_LSB +: $bits(module_id_t)] = head[CFG_SRC_LSB +: $bits(module_id_t)];
      reply[CFG_DATA_LSB +: $bits(counter_t)] = cnt_rdata;
   end

   // ************************************************************************
   // packet FSM
   // ************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= ST_IDLE;
         cout_data_wr <= 1'b0;
      end else begin
         cout_data_wr <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (start) begin
                  if (!for_us) begin
                     state <= ST_FWD;
                  end else if (rd_req) begin
                     state <= ST_WAIT;
                  end else if (is_start && (op == CFG_OP_WRITE)) begin
                     state <= ST_WRITE;
                  end else begin
                     // malformed packet for us
                     state <= ST_DISCARD;
                  end
               end
            end
            ST_WRITE: begin
               state <= ST_DISCARD;
            end
            // counter read in flight
            ST_WAIT: begin
               state <= ST_READ;
            end
            ST_READ: begin
               cout_data_wr <= 1'b1;
               state        <= ST_FWD;
            end
            ST_FWD: begin
               if (!q_empty) begin
                  cout_data_wr <= 1'b1;
                  if (is_end) begin
                     state <= ST_IDLE;
                  end
               end
            end
            ST_DISCARD: begin
               if (!q_empty && is_end) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_READ) begin
         cout_data <= reply;
      end else if (state == ST_FWD) begin
         cout_data <= head;
      end
   end

endmodule

/* gme_pkg.sv */
package gme_pkg;

   // ************************************************************************
   // payload widths
   // ************************************************************************
   typedef logic [511:0]  key_t;
   typedef logic [255:0]  md_t;
   typedef logic [1023:0] phv_t;
   typedef logic [15:0]   index_t;
   typedef logic [7:0]    module_id_t;
   typedef logic [7:0]    cnt_addr_t;
   typedef logic [31:0]   counter_t;
   typedef logic [133:0]  cfg_word_t;

   // one increment request from the dispatch stage
   typedef struct packed {
      logic      stb;
      cnt_addr_t addr;
   } hit_req_t;

   // counter access from the configuration side
   typedef struct packed {
      logic      wr;
      cnt_addr_t addr;
      counter_t  data;
   } cnt_access_t;

   typedef enum logic [2:0] {
      CFG_OP_READ     = 3'd1,
      CFG_OP_WRITE    = 3'd2,
      CFG_OP_READ_ACK = 3'd3
   } cfg_op_t;

   // metadata fields
   localparam int MD_MID_LSB   = 80;
   localparam int MD_IDX_LSB   = 51;
   localparam int MD_IDX_W     = 13;
   localparam int MD_IDX_VALID = 50;

   // configuration word fields
   localparam int CFG_CTL_LSB  = 132;
   localparam int CFG_OP_LSB   = 124;
   localparam int CFG_SRC_LSB  = 104;
   localparam int CFG_DST_LSB  = 96;
   localparam int CFG_ADDR_LSB = 67;
   localparam int CFG_DATA_LSB = 0;

   localparam logic [1:0] CFG_CTL_START = 2'd1;
   localparam logic [1:0] CFG_CTL_END   = 2'd2;

   // queue sizing
   localparam int ALF_LEVEL      = 230;
   localparam int IDX_ALF_LEVEL  = 1020;
   localparam int IDX_FIFO_DEPTH = 1024;
   localparam int CFG_FIFO_DEPTH = 128;

endpackage

/* gme_top.sv */
`timescale 1ns/1ns

module gme_top import gme_pkg::*; #(
   parameter module_id_t LMID       = 8'd3,
   parameter module_id_t NMID       = 8'd4,
   parameter int         FIFO_DEPTH = 256
) (
   input  logic      clk,
   input  logic      rst_n,
   // upstream
   input  md_t       in_md,
   input  logic      in_md_wr,
   input  phv_t      in_phv,
   input  logic      in_phv_wr,
   input  key_t      in_key,
   input  logic      in_key_wr,
   input  index_t    in_index,
   input  logic      in_index_wr,
   input  cfg_word_t cin_data,
   input  logic      cin_data_wr,
   // downstream
   output md_t       out_md,
   output logic      out_md_wr,
   output phv_t      out_phv,
   output logic      out_phv_wr,
   output key_t      out_key,
   output logic      out_key_wr,
   output cfg_word_t cout_data,
   output logic      cout_data_wr,
   // back-pressure
   input  logic      in_md_alf,
   input  logic      in_phv_alf,
   input  logic      in_key_alf,
   input  logic      cin_ready,
   output logic      out_md_alf,
   output logic      out_phv_alf,
   output logic      out_key_alf,
   output logic      out_index_alf,
   output logic      cout_ready
);

   logic [$clog2(FIFO_DEPTH+1)-1:0]     md_level;
   logic [$clog2(FIFO_DEPTH+1)-1:0]     phv_level;
   logic [$clog2(IDX_FIFO_DEPTH+1)-1:0] index_level;
   hit_req_t                            hit;
   cnt_access_t                         cnt_req;
   logic                                cnt_req_vld;
   counter_t                            cnt_rdata;

   // almost-full towards upstream
   assign out_md_alf    = in_md_alf || (md_level > ALF_LEVEL);
   assign out_phv_alf   = in_phv_alf || (phv_level > ALF_LEVEL);
   assign out_key_alf   = in_key_alf;
   assign out_index_alf = (index_level > IDX_ALF_LEVEL);

   match_dispatch #(.LMID(LMID), .NMID(NMID), .FIFO_DEPTH(FIFO_DEPTH)) u_dispatch (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_md       (in_md),
      .in_md_wr    (in_md_wr),
      .in_phv      (in_phv),
      .in_phv_wr   (in_phv_wr),
      .in_index    (in_index),
      .in_index_wr (in_index_wr),
      .in_key      (in_key),
      .in_key_wr   (in_key_wr),
      .out_md      (out_md),
      .out_md_wr   (out_md_wr),
      .out_phv     (out_phv),
      .out_phv_wr  (out_phv_wr),
      .out_key     (out_key),
      .out_key_wr  (out_key_wr),
      .md_level    (md_level),
      .phv_level   (phv_level),
      .index_level (index_level),
      .hit         (hit)
   );

   hit_counter_ram u_counters (
      .clk         (clk),
      .rst_n       (rst_n),
      .hit         (hit),
      .cnt_req     (cnt_req),
      .cnt_req_vld (cnt_req_vld),
      .cnt_rdata   (cnt_rdata)
   );

   cfg_pkt_engine #(.LMID(LMID)) u_cfg_engine (
      .clk          (clk),
      .rst_n        (rst_n),
      .cin_data     (cin_data),
      .cin_data_wr  (cin_data_wr),
      .cin_ready    (cin_ready),
      .cnt_rdata    (cnt_rdata),
      .cout_data    (cout_data),
      .cout_data_wr (cout_data_wr),
      .cout_ready   (cout_ready),
      .cnt_req      (cnt_req),
      .cnt_req_vld  (cnt_req_vld)
   );

endmodule

/* hit_counter_ram.sv */
`timescale 1ns/1ns

module hit_counter_ram import gme_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  hit_req_t    hit,
   input  cnt_access_t cnt_req,
   input  logic        cnt_req_vld,
   output counter_t    cnt_rdata
);

   localparam int N_CNT = 2 ** $bits(cnt_addr_t);

   counter_t  cnt_mem [N_CNT];
   logic      inc_vld;
   cnt_addr_t inc_addr;
   counter_t  inc_old;
   counter_t  inc_new;
   cnt_addr_t rd_addr;
   logic      cfg_wr;

   assign inc_new = inc_old + 1'b1;

   // increment beats a config write on the same address
   assign cfg_wr = cnt_req_vld && cnt_req.wr && !(inc_vld && (inc_addr == cnt_req.addr));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < N_CNT; i++) begin
            cnt_mem[i] <= '0;
         end
      end else begin
         if (cfg_wr) begin
            cnt_mem[cnt_req.addr] <= cnt_req.data;
         end
         if (inc_vld) begin
            cnt_mem[inc_addr] <= inc_new;
         end
      end
   end

   // ************************************************************************
   // port a, read then write back
   // ************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         inc_vld <= 1'b0;
      end else begin
         inc_vld <= hit.stb;
      end
   end

   always_ff @(posedge clk) begin
      if (hit.stb) begin
         inc_addr <= hit.addr;
         // take the value still being written back
         if (inc_vld && (inc_addr == hit.addr)) begin
            inc_old <= inc_new;
         end else begin
            inc_old <= cnt_mem[hit.addr];
         end
      end
   end

   // port b, data out two cycles after the request
   always_ff @(posedge clk) begin
      if (cnt_req_vld && !cnt_req.wr) begin
         rd_addr <= cnt_req.addr;
      end
      cnt_rdata <= cnt_mem[rd_addr];
   end

endmodule

/* match_dispatch.sv */
`timescale 1ns/1ns

module match_dispatch import gme_pkg::*; #(
   parameter module_id_t LMID       = 8'd3,
   parameter module_id_t NMID       = 8'd4,
   parameter int         FIFO_DEPTH = 256
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  md_t                                 in_md,
   input  logic                                in_md_wr,
   input  phv_t                                in_phv,
   input  logic                                in_phv_wr,
   input  index_t                              in_index,
   input  logic                                in_index_wr,
   input  key_t                                in_key,
   input  logic                                in_key_wr,
   output md_t                                 out_md,
   output logic                                out_md_wr,
   output phv_t                                out_phv,
   output logic                                out_phv_wr,
   output key_t                                out_key,
   output logic                                out_key_wr,
   output logic [$clog2(FIFO_DEPTH+1)-1:0]     md_level,
   output logic [$clog2(FIFO_DEPTH+1)-1:0]     phv_level,
   output logic [$clog2(IDX_FIFO_DEPTH+1)-1:0] index_level,
   output hit_req_t                            hit
);

   typedef enum logic {
      ST_IDLE,
      ST_EMIT
   } disp_state_t;

   disp_state_t state;
   md_t         md_head;
   phv_t        phv_head;
   index_t      idx_head;
   logic        md_empty;
   logic        phv_empty;
   logic        idx_empty;
   logic        key_take;
   logic        for_us;
   logic        go;
   logic        matched;
   cnt_addr_t   hit_addr;
   md_t         md_stamped;

   // ************************************************************************
   // key filter towards lookup
   // ************************************************************************
   assign key_take = in_key_wr && (in_md[MD_MID_LSB +: $bits(module_id_t)] == LMID);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_key_wr <= 1'b0;
      end else begin
         out_key_wr <= key_take;
      end
   end

   always_ff @(posedge clk) begin
      if (key_take) begin
         out_key <= in_key;
      end
   end

   // ************************************************************************
   // input queues
   // ************************************************************************
   sync_fifo #(.WIDTH($bits(md_t)), .DEPTH(FIFO_DEPTH)) u_md_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (in_md_wr),
      .din   (in_md),
      .rd    (go),
      .dout  (md_head),
      .empty (md_empty),
      .full  (),
      .level (md_level)
   );

   sync_fifo #(.WIDTH($bits(phv_t)), .DEPTH(FIFO_DEPTH)) u_phv_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (in_phv_wr),
      .din   (in_phv),
      .rd    (go),
      .dout  (phv_head),
      .empty (phv_empty),
      .full  (),
      .level (phv_level)
   );

   sync_fifo #(.WIDTH($bits(index_t)), .DEPTH(IDX_FIFO_DEPTH)) u_idx_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (in_index_wr),
      .din   (in_index),
      .rd    (go && for_us),
      .dout  (idx_head),
      .empty (idx_empty),
      .full  (),
      .level (index_level)
   );

   // ************************************************************************
   // dispatch
   // ************************************************************************
   assign for_us = (md_head[MD_MID_LSB +: $bits(module_id_t)] == LMID);

   // a head for this stage blocks until its index shows up
   assign go = (state == ST_IDLE) && !md_empty && !phv_empty && (!for_us || !idx_empty);

   always_comb begin
      md_stamped = md_head;
      md_stamped[MD_MID_LSB +: $bits(module_id_t)] = NMID;
      md_stamped[MD_IDX_LSB +: MD_IDX_W] = idx_head[MD_IDX_W-1:0];
      md_stamped[MD_IDX_VALID] = 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_IDLE;
         matched <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (go) begin
                  state   <= ST_EMIT;
                  matched <= for_us;
               end
            end
            ST_EMIT: begin
               state <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (go) begin
         out_md   <= for_us ? md_stamped : md_head;
         out_phv  <= phv_head;
         hit_addr <= idx_head[$bits(cnt_addr_t)-1:0];
      end
   end

   // md and phv always leave together
   assign out_md_wr  = (state == ST_EMIT);
   assign out_phv_wr = (state == ST_EMIT);

   assign hit.stb  = (state == ST_EMIT) && matched;
   assign hit.addr = hit_addr;

endmodule

/* sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       wr,
   input  logic [WIDTH-1:0]           din,
   input  logic                       rd,
   output logic [WIDTH-1:0]           dout,
   output logic                       empty,
   output logic                       full,
   output logic [$clog2(DEPTH+1)-1:0] level
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int LW = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic             push;
   logic             pop;

   // overflow and underflow are dropped
   assign push  = wr && !full;
   assign pop   = rd && !empty;
   assign empty = (level == '0);
   assign full  = (level == LW'(DEPTH));

   // show-ahead, head word visible without a read
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            level <= level + 1'b1;
         end else if (pop && !push) begin
            level <= level - 1'b1;
         end
      end
   end

endmodule

/* tb_gme.sv */
`timescale 1ns/1ns

module tb_gme import gme_pkg::*; ();

   localparam int         CLK_PERIOD  = 40;
   localparam module_id_t LMID        = 8'd3;
   localparam module_id_t NMID        = 8'd4;
   localparam int         N_ITEMS     = 64;
   localparam int         DRAIN_LIMIT = 200;

   logic        clk;
   logic        rst_n;
   md_t         in_md;
   logic        in_md_wr;
   phv_t        in_phv;
   logic        in_phv_wr;
   key_t        in_key;
   logic        in_key_wr;
   index_t      in_index;
   logic        in_index_wr;
   cfg_word_t   cin_data;
   logic        cin_data_wr;
   md_t         out_md;
   logic        out_md_wr;
   phv_t        out_phv;
   logic        out_phv_wr;
   key_t        out_key;
   logic        out_key_wr;
   cfg_word_t   cout_data;
   logic        cout_data_wr;
   logic        in_md_alf;
   logic        in_phv_alf;
   logic        in_key_alf;
   logic        cin_ready;
   logic        out_md_alf;
   logic        out_phv_alf;
   logic        out_key_alf;
   logic        out_index_alf;
   logic        cout_ready;

   integer      seed;
   int          errors;
   int          checks;
   int          tests_run;
   int          errs_at_start;
   md_t         exp_md [$];
   phv_t        exp_phv [$];
   key_t        exp_key [$];
   cfg_word_t   exp_cout [$];
   cfg_word_t   pkt [$];
   counter_t    hit_model [256];
   md_t         want_md;
   phv_t        want_phv;
   key_t        want_key;
   cfg_word_t   want_cout;

   gme_top DUT (
      .clk(clk), .rst_n(rst_n),
      .in_md(in_md), .in_md_wr(in_md_wr), .in_phv(in_phv), .in_phv_wr(in_phv_wr),
      .in_key(in_key), .in_key_wr(in_key_wr), .in_index(in_index), .in_index_wr(in_index_wr),
      .cin_data(cin_data), .cin_data_wr(cin_data_wr),
      .out_md(out_md), .out_md_wr(out_md_wr), .out_phv(out_phv), .out_phv_wr(out_phv_wr),
      .out_key(out_key), .out_key_wr(out_key_wr),
      .cout_data(cout_data), .cout_data_wr(cout_data_wr),
      .in_md_alf(in_md_alf), .in_phv_alf(in_phv_alf), .in_key_alf(in_key_alf),
      .cin_ready(cin_ready),
      .out_md_alf(out_md_alf), .out_phv_alf(out_phv_alf), .out_key_alf(out_key_alf),
      .out_index_alf(out_index_alf), .cout_ready(cout_ready)
   );

   always begin
      #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ************************************************************************
   // stimulus helpers
   // ************************************************************************
   function automatic phv_t rand_wide();
      phv_t v;
      for (int i = 0; i < 32; i++) begin
         v[32*i +: 32] = $random(seed);
      end
      return v;
   endfunction

   // metadata as it should leave after a match
   function automatic md_t stamp_md(input md_t md, input index_t idx);
      md_t r;
      r = md;
      r[87:80] = NMID;
      r[63:51] = idx[12:0];
      r[50]    = 1'b1;
      return r;
   endfunction

   function automatic cfg_word_t make_start(input logic [2:0] op, input module_id_t src,
                                            input module_id_t dst, input cnt_addr_t addr,
                                            input counter_t data);
      cfg_word_t w;
      phv_t      wide;
      wide = rand_wide();
      w = wide[133:0];
      w[133:132] = 2'd1;
      w[126:124] = op;
      w[111:104] = src;
      w[103:96]  = dst;
      w[74:67]   = addr;
      w[31:0]    = data;
      return w;
   endfunction

   function automatic cfg_word_t make_tail(input logic [1:0] ctl);
      cfg_word_t w;
      phv_t      wide;
      wide = rand_wide();
      w = wide[133:0];
      w[133:132] = ctl;
      return w;
   endfunction

   // read ack: op 3, ids swapped, counter in the low word
   function automatic cfg_word_t expect_reply(input cfg_word_t w, input counter_t cnt);
      cfg_word_t r;
      r = w;
      r[126:124] = 3'd3;
      r[111:104] = w[103:96];
      r[103:96]  = w[111:104];
      r[31:0]    = cnt;
      return r;
   endfunction

   task automatic next_slot();
      @(posedge clk);
      #5;
   endtask

   task automatic idle_upstream();
      in_md_wr    = 1'b0;
      in_phv_wr   = 1'b0;
      in_key_wr   = 1'b0;
      in_index_wr = 1'b0;
   endtask

   // one md/phv/key triple, plus an index when the item is for this stage
   task automatic send_item(input module_id_t id, input logic with_idx, input index_t idx);
      md_t  md;
      phv_t phv;
      key_t key;
      phv_t wide;
      wide = rand_wide();
      md = wide[255:0];
      md[87:80] = id;
      phv = rand_wide();
      wide = rand_wide();
      key = wide[511:0];
      exp_phv.push_back(phv);
      if (id == LMID) begin
         exp_md.push_back(stamp_md(md, idx));
         exp_key.push_back(key);
         hit_model[idx[7:0]] = hit_model[idx[7:0]] + 1;
      end else begin
         exp_md.push_back(md);
      end
      next_slot();
      in_md       = md;
      in_md_wr    = 1'b1;
      in_phv      = phv;
      in_phv_wr   = 1'b1;
      in_key      = key;
      in_key_wr   = 1'b1;
      in_index    = idx;
      in_index_wr = with_idx && (id == LMID);
      next_slot();
      idle_upstream();
   endtask

   task automatic send_index(input index_t idx);
      next_slot();
      in_index    = idx;
      in_index_wr = 1'b1;
      next_slot();
      idle_upstream();
   endtask

   // key only, qualified by the metadata on the bus
   task automatic send_key(input module_id_t id);
      phv_t wide;
      wide = rand_wide();
      next_slot();
      in_md        = wide[255:0];
      in_md[87:80] = id;
      wide = rand_wide();
      in_key    = wide[511:0];
      in_key_wr = 1'b1;
      if (id == LMID) begin
         exp_key.push_back(in_key);
      end
      next_slot();
      idle_upstream();
   endtask

   task automatic send_packet();
      while (pkt.size() > 0) begin
         next_slot();
         cin_data    = pkt.pop_front();
         cin_data_wr = 1'b1;
      end
      next_slot();
      cin_data_wr = 1'b0;
   endtask

   task automatic wait_drain(input string what);
      int n;
      n = 0;
      while ((exp_md.size() + exp_phv.size() + exp_key.size() + exp_cout.size()) != 0 &&
             n < DRAIN_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (n >= DRAIN_LIMIT) begin
         $display("%s: expected outputs still missing after %0d cycles", what, n);
         errors++;
      end
   endtask

   task automatic read_counter(input cnt_addr_t addr);
      cfg_word_t first;
      cfg_word_t mid;
      cfg_word_t last;
      first = make_start(3'd1, 8'h21, LMID, addr, $random(seed));
      mid   = make_tail(2'd0);
      last  = make_tail(2'd2);
      exp_cout.push_back(expect_reply(first, hit_model[addr]));
      exp_cout.push_back(mid);
      exp_cout.push_back(last);
      pkt.push_back(first);
      pkt.push_back(mid);
      pkt.push_back(last);
      send_packet();
      wait_drain("counter read");
   endtask

   task automatic check_flag(input string name, input logic got, input logic want);
      checks++;
      assert (got === want) else begin
         $display("MISMATCH %s: got %h expected %h", name, got, want);
         errors++;
      end
   endtask

   task automatic set_alf(input logic md_alf, input logic phv_alf, input logic key_alf);
      next_slot();
      in_md_alf  = md_alf;
      in_phv_alf = phv_alf;
      in_key_alf = key_alf;
      @(negedge clk);
      check_flag("out_md_alf", out_md_alf, md_alf);
      check_flag("out_phv_alf", out_phv_alf, phv_alf);
      check_flag("out_key_alf", out_key_alf, key_alf);
      check_flag("out_index_alf", out_index_alf, 1'b0);
      check_flag("cout_ready", cout_ready, 1'b1);
   endtask

   task automatic end_test(input int num, input string name);
      tests_run++;
      $display("test %0d %s: %0d errors", num, name, errors - errs_at_start);
      errs_at_start = errors;
   endtask

   // ************************************************************************
   // output checkers, sampled mid-cycle
   // ************************************************************************
   always @(negedge clk) begin
      if (rst_n && out_md_wr) begin
         checks++;
         assert (exp_md.size() > 0 && exp_phv.size() > 0) else begin
            $display("metadata left the DUT when none was expected");
            errors++;
         end
         if (exp_md.size() > 0 && exp_phv.size() > 0) begin
            want_md  = exp_md.pop_front();
            want_phv = exp_phv.pop_front();
            assert (out_md === want_md) else begin
               $display("MISMATCH out_md: got %h expected %h", out_md, want_md);
               errors++;
            end
            assert (out_phv === want_phv) else begin
               $display("MISMATCH out_phv: got %h expected %h", out_phv, want_phv);
               errors++;
            end
         end
      end
      if (rst_n && out_key_wr) begin
         checks++;
         assert (exp_key.size() > 0) else begin
            $display("a key reached out_key although none was expected");
            errors++;
         end
         if (exp_key.size() > 0) begin
            want_key = exp_key.pop_front();
            assert (out_key === want_key) else begin
               $display("MISMATCH out_key: got %h expected %h", out_key, want_key);
               errors++;
            end
         end
      end
      if (rst_n && cout_data_wr) begin
         checks++;
         assert (exp_cout.size() > 0) else begin
            $display("a configuration word left the DUT when none was expected");
            errors++;
         end
         if (exp_cout.size() > 0) begin
            want_cout = exp_cout.pop_front();
            assert (cout_data === want_cout) else begin
               $display("MISMATCH cout_data: got %h expected %h", cout_data, want_cout);
               errors++;
            end
         end
      end
   end

   strobes_paired: assert property (@(posedge clk) disable iff (!rst_n)
                                    out_md_wr == out_phv_wr)
      else begin
         $display("out_md_wr and out_phv_wr disagree");
         errors++;
      end

   // watchdog
   initial begin
      #(CLK_PERIOD * (N_ITEMS * 20 + 200));
      $display("watchdog expired before the tests completed");
      $display("TEST FAILED");
      $finish;
   end

   // ************************************************************************
   // test sequence
   // ************************************************************************
   initial begin
      cnt_addr_t a;
      cnt_addr_t b;
      counter_t  v;
      index_t    idx;
      module_id_t id;
      clk = 1'b0;
      rst_n = 1'b0;
      seed = 32'hb955_fea2;
      errors = 0;
      checks = 0;
      tests_run = 0;
      errs_at_start = 0;
      in_md = '0;
      in_phv = '0;
      in_key = '0;
      in_index = '0;
      cin_data = '0;
      cin_data_wr = 1'b0;
      in_md_alf = 1'b0;
      in_phv_alf = 1'b0;
      in_key_alf = 1'b0;
      cin_ready = 1'b1;
      idle_upstream();
      for (int i = 0; i < 256; i++) begin
         hit_model[i] = '0;
      end
      repeat (2) @(posedge clk);
      #5;
      rst_n = 1'b1;
      @(negedge clk);
      check_flag("out_md_wr", out_md_wr, 1'b0);
      check_flag("out_key_wr", out_key_wr, 1'b0);
      check_flag("cout_data_wr", cout_data_wr, 1'b0);

      for (int i = 0; i < 8; i++) begin
         id = $random(seed);
         if (id == LMID) begin
            id = id + 1;
         end
         send_item(id, 1'b0, '0);
      end
      wait_drain("pass-through");
      end_test(1, "pass-through");

      for (int i = 0; i < 8; i++) begin
         idx = $random(seed);
         send_item((i % 3 == 2) ? 8'h11 : LMID, 1'b1, idx);
      end
      // index arrives late, the pass item behind it has to wait
      idx = $random(seed);
      send_item(LMID, 1'b0, idx);
      send_item(8'h12, 1'b0, '0);
      repeat (4) @(posedge clk);
      send_index(idx);
      wait_drain("match rewrite");
      end_test(2, "match rewrite");

      for (int i = 0; i < 8; i++) begin
         send_key((i % 2 == 0) ? LMID : 8'(i + 8));
      end
      wait_drain("key filter");
      end_test(3, "key filter");

      a = $random(seed);
      for (int i = 0; i < 5; i++) begin
         idx = {8'($random(seed)), a};
         send_item(LMID, 1'b1, idx);
      end
      wait_drain("hit count");
      read_counter(a);
      end_test(4, "hit count read");

      b = a + 8'd1;
      v = $random(seed);
      hit_model[b] = v;
      pkt.push_back(make_start(3'd2, 8'h21, LMID, b, v));
      pkt.push_back(make_tail(2'd2));
      send_packet();
      read_counter(b);
      pkt.push_back(make_start(3'd1, 8'h21, 8'h07, a, $random(seed)));
      pkt.push_back(make_tail(2'd0));
      pkt.push_back(make_tail(2'd2));
      foreach (pkt[i]) begin
         exp_cout.push_back(pkt[i]);
      end
      send_packet();
      wait_drain("forwarding");
      end_test(5, "config write and forwarding");

      set_alf(1'b1, 1'b0, 1'b0);
      set_alf(1'b0, 1'b1, 1'b0);
      set_alf(1'b0, 1'b0, 1'b1);
      set_alf(1'b0, 1'b0, 1'b0);
      // nothing may leave while downstream is not ready
      next_slot();
      cin_ready = 1'b0;
      pkt.push_back(make_start(3'd1, 8'h21, 8'h09, a, $random(seed)));
      pkt.push_back(make_tail(2'd2));
      foreach (pkt[i]) begin
         exp_cout.push_back(pkt[i]);
      end
      send_packet();
      repeat (10) begin
         @(negedge clk);
         check_flag("cout_data_wr", cout_data_wr, 1'b0);
      end
      checks++;
      assert (exp_cout.size() == 2) else begin
         $display("configuration words left the DUT while cin_ready was low");
         errors++;
      end
      next_slot();
      cin_ready = 1'b1;
      wait_drain("almost-full");
      end_test(6, "almost-full");

      repeat (4) @(posedge clk);
      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* vlog.f */
gme_pkg.sv
sync_fifo.sv
match_dispatch.sv
hit_counter_ram.sv
cfg_pkt_engine.sv
gme_top.sv
tb_gme.sv
